/* verilog.f */
+incdir+common
common/gpio_pkg.sv
common/gpio_bus_if.sv
src/gpio_regs.sv
gpio_pins/gpio_pin_map.sv
gpio_pins/gpio_input_capture.sv
src/gpio_top.sv
sim/gpio_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the GPIO testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f verilog.f --top-module gpio_tb \
  -o gpio_tb_sim > build.log 2>&1 \
  && ./obj_dir/gpio_tb_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0

/* sim/gpio_tb.sv */
// ====================
// GPIO controller testbench
// Table-driven register accesses, pad
// loopback model, edge interrupts and
// response back-pressure
// ====================
`timescale 1ns/100ps
`default_nettype none

`include "gpio_consts.svh"

module gpio_tb;
  import gpio_pkg::*;

  localparam int NP = `GPIO_NUM_PAIRS;
  localparam int NS = `GPIO_SIGS;

  typedef enum logic [2:0] {
    OP_WR, OP_RD, OP_WAIT, OP_PAD, OP_PADO, OP_PADOE, OP_IRQ, OP_BP
  } op_e;

  typedef struct packed {
    op_e        op;
    gpio_addr_t addr;
    gpio_data_t data;  // Write data, wait cycles, pad levels
    gpio_data_t exp;   // Expected value
  } row_t;

  logic          clk;
  logic          arst_n;
  logic          req_valid;
  logic          req_write;
  logic          rsp_ready;
  gpio_addr_t    req_addr;
  gpio_data_t    req_wdata;
  logic          req_ready;
  logic          rsp_valid;
  gpio_data_t    rsp_rdata;
  logic [NP-1:0] pad_p_i;
  logic [NP-1:0] pad_n_i;
  logic [NP-1:0] pad_p_o;
  logic [NP-1:0] pad_n_o;
  logic [NP-1:0] pad_p_oe;
  logic [NP-1:0] pad_n_oe;
  logic          irq;
  gpio_data_t    stim;        // Pad levels {N, P}
  gpio_data_t    out_m;       // Register model
  gpio_data_t    dir_m;
  gpio_data_t    en_m;
  gpio_data_t    stim_m;
  row_t          rows[$];
  int            errors;
  int            n_rows;
  logic          table_done;

  // Driven pads read back their own value
  assign pad_p_i = (pad_p_oe & pad_p_o) | (~pad_p_oe & stim[NP-1:0]);
  assign pad_n_i = (pad_n_oe & pad_n_o) | (~pad_n_oe & stim[2*NP-1:NP]);

  always #20 clk = ~clk;

  gpio_top DUT (
    .clk, .arst_n, .bus_req_valid(req_valid), .bus_req_write(req_write),
    .bus_rsp_ready(rsp_ready), .bus_req_addr(req_addr), .bus_req_wdata(req_wdata),
    .bus_req_ready(req_ready), .bus_rsp_valid(rsp_valid), .bus_rsp_rdata(rsp_rdata),
    .pad_p_i, .pad_n_i, .pad_p_o, .pad_n_o, .pad_p_oe, .pad_n_oe, .irq
  );

  // Bit of the {N, P} pad word that carries signal s
  function automatic int pad_bit(input int s);
    if (`GPIO_DIFF == 1) return s;
    if (s % 4 < 2) return NP + 2 * (s / 4) + s % 4; // First two of a group on N
    return 2 * (s / 4) + s % 4 - 2;
  endfunction

  function automatic gpio_data_t pad_word(input gpio_data_t v, input logic inv_n);
    gpio_data_t w;
    w = '0;
    for (int s = 0; s < NS; s++) begin
      w[pad_bit(s)] = v[s];
      if (`GPIO_DIFF == 1) w[NP + s] = v[s] ^ inv_n; // N is the complement
    end
    return w;
  endfunction

  function automatic gpio_data_t exp_in();
    gpio_data_t w;
    for (int s = 0; s < `GPIO_DATA_W; s++) begin
      if (s >= NS) w[s] = out_m[s] & ~dir_m[s];          // Loopback bits
      else w[s] = dir_m[s] ? stim_m[pad_bit(s)] : out_m[s];
    end
    return w;
  endfunction

  task automatic add_row(input op_e op, input gpio_addr_t a, input gpio_data_t d,
                         input gpio_data_t e);
    row_t r;
    r.op   = op;
    r.addr = a;
    r.data = d;
    r.exp  = e;
    rows.push_back(r);
  endtask

  task automatic add_wr(input gpio_addr_t a, input gpio_data_t d);
    if (a == REG_OUT) out_m = d;
    if (a == REG_DIR) dir_m = d;
    if (a == REG_IRQ_EN) en_m = d;
    add_row(OP_WR, a, d, '0);
  endtask

  task automatic add_pad(input gpio_data_t d);
    stim_m = d;
    add_row(OP_PAD, '0, d, '0);
    add_row(OP_WAIT, '0, 8, '0); // Sync and event path
  endtask

  task automatic add_stat(input gpio_data_t e);
    add_row(OP_RD, REG_IRQ_STAT, '0, e);
    add_row(OP_IRQ, '0, '0, gpio_data_t'(|(e & en_m)));
  endtask

  task automatic build_table();
    out_m  = '0;
    dir_m  = '1;
    en_m   = '0;
    stim_m = '0;
    add_row(OP_RD, REG_OUT, '0, '0);        // Reset values
    add_row(OP_RD, REG_DIR, '0, '1);
    add_row(OP_RD, REG_IN, '0, exp_in());
    add_row(OP_RD, REG_EDGE, '0, '0);
    add_row(OP_RD, REG_IRQ_EN, '0, '0);
    add_row(OP_RD, 3'd6, '0, '0);           // Unmapped
    add_stat('0);
    add_row(OP_PADOE, '0, '0, '0);
    add_wr(REG_OUT, 32'hA5C3_96F0);
    add_wr(REG_DIR, 32'h0F0F_33CC);
    add_row(OP_PADO, '0, '0, pad_word(out_m, 1'b1));
    add_row(OP_PADOE, '0, '0, pad_word(~dir_m, 1'b0));
    add_pad($urandom);
    add_row(OP_RD, REG_IN, '0, exp_in());
    add_wr(REG_DIR, 32'h3C00_5AF0);
    add_row(OP_PADOE, '0, '0, pad_word(~dir_m, 1'b0));
    add_pad($urandom);
    add_row(OP_RD, REG_IN, '0, exp_in());
    add_row(OP_BP, REG_OUT, dir_m, out_m);  // Queued DIR read behind it
    add_wr(REG_OUT, 32'h1234_5678);
    add_pad(stim_m);
    add_row(OP_BP, REG_IN, dir_m, exp_in());
    add_wr(REG_DIR, '1);                    // All inputs for edges
    add_pad('0);
    add_wr(REG_EDGE, 32'h1);                // Bit 0 rising, bit 1 falling
    add_wr(REG_IRQ_EN, 32'h3);
    add_row(OP_RD, REG_EDGE, '0, 32'h1);
    add_row(OP_RD, REG_IRQ_EN, '0, 32'h3);
    add_wr(REG_IRQ_STAT, '1);
    add_stat('0);
    add_pad(gpio_data_t'(1) << pad_bit(0)); // Matching rise
    add_stat(32'h1);
    add_wr(REG_IRQ_STAT, 32'h1);
    add_stat('0);
    add_pad('0);                            // Opposite edge on bit 0
    add_stat('0);
    add_pad(gpio_data_t'(1) << pad_bit(1)); // Opposite edge on bit 1
    add_stat('0);
    add_pad('0);
    add_stat(32'h2);
    add_wr(REG_IRQ_STAT, 32'h2);
    add_stat('0);
  endtask

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check(input string what, input gpio_data_t got, input gpio_data_t exp);
    assert (got === exp)
      else begin
        errors++;
        $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
  endtask

  task automatic send_req(input logic wr, input gpio_addr_t a, input gpio_data_t d);
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = a;
    req_wdata = d;
    while (!req_ready) tick();
    tick(); // Transfers on this edge
  endtask

  task automatic take_rsp(output gpio_data_t rd);
    rsp_ready = 1'b1;
    while (!rsp_valid) tick();
    rd = rsp_rdata;
    tick();
    rsp_ready = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    gpio_data_t rd;
    gpio_data_t hold;
    int         stall;
    case (r.op)
      OP_WR: begin
        send_req(1'b1, r.addr, r.data);
        req_valid = 1'b0;
        take_rsp(rd);
        check($sformatf("write response of reg %0d", r.addr), rd, '0);
      end
      OP_RD: begin
        send_req(1'b0, r.addr, '0);
        req_valid = 1'b0;
        take_rsp(rd);
        check($sformatf("read of reg %0d", r.addr), rd, r.exp);
      end
      OP_WAIT:  repeat (r.data) tick();
      OP_PAD:   stim = r.data;
      OP_PADO:  check("pad outputs", gpio_data_t'({pad_n_o, pad_p_o}), r.exp);
      OP_PADOE: check("pad enables", gpio_data_t'({pad_n_oe, pad_p_oe}), r.exp);
      OP_IRQ:   check("irq", gpio_data_t'(irq), r.exp);
      default: begin
        stall = 1 + int'($urandom % 8);
        send_req(1'b0, r.addr, '0);
        req_addr = REG_DIR;  // Second request waits behind the first
        hold = rsp_rdata;
        repeat (stall) begin
          assert (rsp_valid && rsp_rdata === hold && !req_ready)
            else begin
              errors++;
              $display("Response not held or request accepted at %0t ns", $time);
            end
          tick();
        end
        take_rsp(rd);
        check($sformatf("stalled read of reg %0d", r.addr), rd, r.exp);
        send_req(1'b0, REG_DIR, '0);
        req_valid = 1'b0;
        take_rsp(rd);
        check("queued read of DIR", rd, r.data);
      end
    endcase
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    rsp_ready  = 1'b0;
    stim       = '0;
    errors     = 0;
    table_done = 1'b0;
    void'($urandom(86));
    build_table();
    n_rows     = rows.size();
    table_done = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    foreach (rows[i]) apply_row(rows[i]);
    $display("%0d rows applied, %0d errors", n_rows, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog, 20 cycles per row
  initial begin
    wait (table_done);
    repeat (10 + n_rows * 20) @(posedge clk);
    $display("Run timed out after %0d cycles", 10 + n_rows * 20);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* src/gpio_top.sv */
// ====================
// GPIO controller top
// Register block, pin mapper and input
// capture behind a plain register bus
// ====================
`timescale 1ns/100ps
`default_nettype none

`include "gpio_consts.svh"

module gpio_top (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       bus_req_valid,
  input  logic                       bus_req_write,
  input  logic                       bus_rsp_ready,
  input  gpio_pkg::gpio_addr_t       bus_req_addr,
  input  gpio_pkg::gpio_data_t       bus_req_wdata,
  output logic                       bus_req_ready,
  output logic                       bus_rsp_valid,
  output gpio_pkg::gpio_data_t       bus_rsp_rdata,
  input  logic [`GPIO_NUM_PAIRS-1:0] pad_p_i,
  input  logic [`GPIO_NUM_PAIRS-1:0] pad_n_i,
  output logic [`GPIO_NUM_PAIRS-1:0] pad_p_o,
  output logic [`GPIO_NUM_PAIRS-1:0] pad_n_o,
  output logic [`GPIO_NUM_PAIRS-1:0] pad_p_oe,
  output logic [`GPIO_NUM_PAIRS-1:0] pad_n_oe,
  output logic                       irq
);
  import gpio_pkg::*;

  gpio_data_t            out_q;
  gpio_data_t            dir_q;
  gpio_data_t            loop_in;  // From pin mapper
  logic [`GPIO_SIGS-1:0] pin_in;   // Raw pad levels
  logic [`GPIO_SIGS-1:0] in_sync;
  logic [`GPIO_SIGS-1:0] rise_evt;
  logic [`GPIO_SIGS-1:0] fall_evt;

  gpio_bus_if bus_if (); // Host side tied to the ports

  assign bus_if.req_valid = bus_req_valid;
  assign bus_if.req_write = bus_req_write;
  assign bus_if.req_addr  = bus_req_addr;
  assign bus_if.req_wdata = bus_req_wdata;
  assign bus_if.rsp_ready = bus_rsp_ready;
  assign bus_req_ready    = bus_if.req_ready;
  assign bus_rsp_valid    = bus_if.rsp_valid;
  assign bus_rsp_rdata    = bus_if.rsp_rdata;

  gpio_regs u_regs (
    .clk, .arst_n, .bus(bus_if.dev), .in_sync, .rise_evt, .fall_evt,
    .loop_in, .out_q, .dir_q, .irq
  );

  gpio_pin_map u_pin_map (
    .out_q, .dir_q, .pad_p_i, .pad_n_i, .pad_p_o, .pad_n_o,
    .pad_p_oe, .pad_n_oe, .pin_in, .loop_in
  );

  gpio_input_capture u_capture (
    .clk, .arst_n, .pin_in, .in_sync, .rise_evt, .fall_evt
  );

endmodule

`default_nettype wire

/* gpio_pins/gpio_input_capture.sv */
// ====================
// GPIO input capture
// Synchronizes pad levels and turns
// level changes into edge pulses
// ====================
`timescale 1ns/100ps
`default_nettype none

`include "gpio_consts.svh"

module gpio_input_capture (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`GPIO_SIGS-1:0] pin_in,   // Asynchronous pad levels
  output logic [`GPIO_SIGS-1:0] in_sync,  // Level after two flops
  output logic [`GPIO_SIGS-1:0] rise_evt, // One-cycle pulse on 0 -> 1
  output logic [`GPIO_SIGS-1:0] fall_evt  // One-cycle pulse on 1 -> 0
);
  import gpio_pkg::*;

  logic [`GPIO_SIGS-1:0] sync1_q; // First stage that may go metastable
  logic [`GPIO_SIGS-1:0] sync2_q; // Safe level
  logic [`GPIO_SIGS-1:0] prev_q;  // Level one cycle back
  logic [`GPIO_SIGS-1:0] rise_q;
  logic [`GPIO_SIGS-1:0] fall_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= pin_in;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // Events registered one edge after the level
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rise_q <= '0;
      fall_q <= '0;
    end else begin
      rise_q <= sync2_q & ~prev_q;
      fall_q <= ~sync2_q & prev_q;
    end
  end

  assign in_sync  = sync2_q;
  assign rise_evt = rise_q;
  assign fall_evt = fall_q;

  // Each event lasts a single cycle
  a_evt_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    ((rise_evt & $past(rise_evt)) | (fall_evt & $past(fall_evt))) == '0)
    else $error("edge event held for more than one cycle");

endmodule

`default_nettype wire

/* gpio_pins/gpio_pin_map.sv */
// ====================
// GPIO pin mapper
// Spreads controller signals over the
// P/N pad pairs, single-ended or
// differential, loops back the rest
// ====================
`timescale 1ns/100ps
`default_nettype none

`include "gpio_consts.svh"

module gpio_pin_map (
  input  gpio_pkg::gpio_data_t       out_q,    // Output value
  input  gpio_pkg::gpio_data_t       dir_q,    // 1 = input
  input  logic [`GPIO_NUM_PAIRS-1:0] pad_p_i,  // Sampled P pads
  input  logic [`GPIO_NUM_PAIRS-1:0] pad_n_i,  // Sampled N pads
  output logic [`GPIO_NUM_PAIRS-1:0] pad_p_o,
  output logic [`GPIO_NUM_PAIRS-1:0] pad_n_o,
  output logic [`GPIO_NUM_PAIRS-1:0] pad_p_oe, // 1 = driving
  output logic [`GPIO_NUM_PAIRS-1:0] pad_n_oe,
  output logic [`GPIO_SIGS-1:0]      pin_in,   // Pad level per signal
  output gpio_pkg::gpio_data_t       loop_in   // Loopback word
);
  import gpio_pkg::*;

  genvar k;
  genvar n;

  generate
    if (`GPIO_DIFF == 1) begin : g_diff
      // One signal per pair with the complement on N
      assign pad_p_o  = out_q[`GPIO_NUM_PAIRS-1:0];
      assign pad_n_o  = ~out_q[`GPIO_NUM_PAIRS-1:0];
      assign pad_p_oe = ~dir_q[`GPIO_NUM_PAIRS-1:0];
      assign pad_n_oe = ~dir_q[`GPIO_NUM_PAIRS-1:0];
      assign pin_in   = pad_p_i; // Input taken from P
    end else begin : g_se
      // Groups of four signals with two on N and two on P
      for (k = 0; k < `GPIO_NUM_PAIRS / 2; k++) begin : g_grp
        assign pad_n_o[2*k]   = out_q[4*k];
        assign pad_n_o[2*k+1] = out_q[4*k+1];
        assign pad_p_o[2*k]   = out_q[4*k+2];
        assign pad_p_o[2*k+1] = out_q[4*k+3];

        assign pad_n_oe[2*k]   = ~dir_q[4*k];
        assign pad_n_oe[2*k+1] = ~dir_q[4*k+1];
        assign pad_p_oe[2*k]   = ~dir_q[4*k+2];
        assign pad_p_oe[2*k+1] = ~dir_q[4*k+3];

        assign pin_in[4*k]   = pad_n_i[2*k];
        assign pin_in[4*k+1] = pad_n_i[2*k+1];
        assign pin_in[4*k+2] = pad_p_i[2*k];
        assign pin_in[4*k+3] = pad_p_i[2*k+1];
      end
    end
  endgenerate

  // Signals without a pad see their own output
  assign loop_in[`GPIO_SIGS-1:0] = '0;

  generate
    for (n = `GPIO_SIGS; n < `GPIO_DATA_W; n++) begin : g_loop
      assign loop_in[n] = out_q[n] & ~dir_q[n];
    end
  endgenerate

endmodule

`default_nettype wire

/* src/gpio_regs.sv */
// ====================
// GPIO register block
// Decodes bus requests, holds output,
// direction and interrupt settings,
// keeps the sticky interrupt status
// ====================
`timescale 1ns/100ps
`default_nettype none

`include "gpio_consts.svh"

module gpio_regs (
  input  logic                   clk,
  input  logic                   arst_n,
  gpio_bus_if.dev                bus,
  input  logic [`GPIO_SIGS-1:0]  in_sync,   // Synchronized pin level
  input  logic [`GPIO_SIGS-1:0]  rise_evt,  // Rising edge pulses
  input  logic [`GPIO_SIGS-1:0]  fall_evt,  // Falling edge pulses
  input  gpio_pkg::gpio_data_t   loop_in,   // Loopback of missing pins
  output gpio_pkg::gpio_data_t   out_q,     // Output value
  output gpio_pkg::gpio_data_t   dir_q,     // 1 = input
  output logic                   irq        // Combined interrupt
);
  import gpio_pkg::*;

  gpio_data_t            edge_q;      // 1 = rising
  gpio_data_t            irq_en_q;    // Per-bit enable
  logic [`GPIO_SIGS-1:0] irq_stat_q;  // Sticky status
  logic                  rsp_valid_q; // Response pending
  gpio_data_t            rsp_rdata_q; // Held read data
  gpio_data_t            rd_data;     // Read mux
  gpio_data_t            in_word;     // IN register view
  logic                  req_fire;
  logic                  rsp_fire;
  logic                  wr_stat;     // W1C write to status
  logic [`GPIO_SIGS-1:0] evt_hit;     // Selected edge seen

  assign req_fire = bus.req_valid & bus.req_ready;
  assign rsp_fire = bus.rsp_valid & bus.rsp_ready;

  // One outstanding request at most
  assign bus.req_ready = ~rsp_valid_q;
  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rsp_rdata_q;

  // Pins in the low bits with loopback above
  assign in_word = {loop_in[`GPIO_DATA_W-1:`GPIO_SIGS], in_sync};

  always_comb begin
    case (bus.req_addr)
      REG_OUT:      rd_data = out_q;
      REG_DIR:      rd_data = dir_q;
      REG_IN:       rd_data = in_word;
      REG_EDGE:     rd_data = edge_q;
      REG_IRQ_EN:   rd_data = irq_en_q;
      REG_IRQ_STAT: rd_data = gpio_data_t'(irq_stat_q);
      default:      rd_data = '0; // Unmapped reads 0
    endcase
  end

  // Register writes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_q    <= '0;
      dir_q    <= '1; // All inputs
      edge_q   <= '0; // Falling
      irq_en_q <= '0;
    end else if (req_fire && bus.req_write) begin
      case (bus.req_addr)
        REG_OUT:    out_q    <= bus.req_wdata;
        REG_DIR:    dir_q    <= bus.req_wdata;
        REG_EDGE:   edge_q   <= bus.req_wdata;
        REG_IRQ_EN: irq_en_q <= bus.req_wdata;
        default:    ;        // IN, status, unmapped
      endcase
    end
  end

  // Interrupt status
  assign evt_hit = (rise_evt & edge_q[`GPIO_SIGS-1:0]) |
                   (fall_evt & ~edge_q[`GPIO_SIGS-1:0]);
  assign wr_stat = req_fire & bus.req_write & (bus.req_addr == REG_IRQ_STAT);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      irq_stat_q <= '0;
    end else if (wr_stat) begin
      irq_stat_q <= (irq_stat_q & ~bus.req_wdata[`GPIO_SIGS-1:0]) | evt_hit; // Set wins
    end else begin
      irq_stat_q <= irq_stat_q | evt_hit;
    end
  end

  assign irq = |(irq_stat_q & irq_en_q[`GPIO_SIGS-1:0]);

  // Response handshake
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_fire) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rsp_rdata_q <= bus.req_write ? '0 : rd_data; // Writes answer 0
    end
  end

  // Response held while the host stalls
  a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    bus.rsp_valid && !bus.rsp_ready |=> bus.rsp_valid && $stable(bus.rsp_rdata))
    else $error("response changed under back-pressure");

  // Accepted request leaves a pending response that blocks the bus
  a_one_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
    req_fire |=> bus.rsp_valid && !bus.req_ready)
    else $error("accepted request left no pending response");

endmodule

`default_nettype wire

/* common/gpio_bus_if.sv */
// ====================
// GPIO register bus
// Request/response handshake, one
// response per request
// ====================
`timescale 1ns/100ps
`default_nettype none

interface gpio_bus_if;
  import gpio_pkg::*;

  logic       req_valid;  // Request offered
  logic       req_ready;  // Device can accept
  logic       req_write;  // 1 = write
  gpio_addr_t req_addr;   // Register offset
  gpio_data_t req_wdata;  // Write data
  logic       rsp_valid;  // Response offered
  logic       rsp_ready;  // Host can take it
  gpio_data_t rsp_rdata;  // Read data, 0 on writes

  modport host (
    output req_valid, req_write, req_addr, req_wdata, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport dev (
    input  req_valid, req_write, req_addr, req_wdata, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

`default_nettype wire

/* common/gpio_pkg.sv */
// ====================
// GPIO controller types
// Register offsets and bus word types
// ====================
`default_nettype none

`include "gpio_consts.svh"

package gpio_pkg;

  typedef logic [`GPIO_DATA_W-1:0] gpio_data_t; // Register data word
  typedef logic [`GPIO_ADDR_W-1:0] gpio_addr_t; // Register offset

  // Register map
  typedef enum gpio_addr_t {
    REG_OUT      = `GPIO_ADDR_OUT,      // Output value
    REG_DIR      = `GPIO_ADDR_DIR,      // Direction, 1 = input
    REG_IN       = `GPIO_ADDR_IN,       // Synchronized pins
    REG_EDGE     = `GPIO_ADDR_EDGE,     // Edge select
    REG_IRQ_EN   = `GPIO_ADDR_IRQ_EN,   // IRQ enable
    REG_IRQ_STAT = `GPIO_ADDR_IRQ_STAT  // IRQ status
  } gpio_reg_e;

endpackage

`default_nettype wire

/* common/gpio_consts.svh */
// ====================
// GPIO controller constants
// Pad pair count, signal mode, bus widths
// and register offsets
// ====================
`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

`define GPIO_NUM_PAIRS 12 // P/N pad pairs, even
`define GPIO_DIFF 0       // 1 = differential pairs
`define GPIO_SIGS ((`GPIO_DIFF == 1) ? `GPIO_NUM_PAIRS : 2 * `GPIO_NUM_PAIRS)

`define GPIO_DATA_W 32    // Register word
`define GPIO_ADDR_W 3     // Register offset

`define GPIO_ADDR_OUT 3'd0      // Output value
`define GPIO_ADDR_DIR 3'd1      // 1 = input
`define GPIO_ADDR_IN 3'd2       // Read only
`define GPIO_ADDR_EDGE 3'd3     // 1 = rising
`define GPIO_ADDR_IRQ_EN 3'd4   // Per-bit enable
`define GPIO_ADDR_IRQ_STAT 3'd5 // W1C sticky

`endif
